// File: sources.f
logic/frame_pkg.sv
logic/frame_port_if.sv
logic/brush_painter.sv
logic/frame_store.sv
logic/palette_display.sv
logic/sd_image_sequencer.sv
logic/frame_buffer_top.sv
verification/frame_checker.sv
verification/tb_frame_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the frame buffer testbench with Verilator
# the run counts as passed only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_frame_buffer -f sources.f \
        -o sim_frame_buffer \
    && ./obj_dir/sim_frame_buffer | tee /dev/stderr | grep -q "All checks passed" \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

// File: verification/tb_frame_buffer.sv
`timescale 1ns/100ps

module tb_frame_buffer import frame_pkg::*; ();

    localparam int CARD_AW    = 12;            // header plus three images fit
    localparam int CARD_BYTES = 2**CARD_AW;
    localparam int BUSY_LIMIT = 20000;         // cycles for one save or load
    localparam int CARD_LIMIT = 16;            // cycles for the card to settle

    logic        clk_25mhz = 1'b0;
    logic        reset_SD_card;
    x_t          hcount;
    y_t          vcount;
    x_t          brush_x;
    y_t          brush_y;
    color_t      brush_color;
    brush_size_t brush_size;
    logic        draw;
    logic        slide_show;
    logic        sd_rd;
    logic        sd_wr;
    sd_addr_t    sd_addr;
    sd_byte_t    sd_din;
    logic        sd_ready;
    sd_byte_t    sd_dout;
    logic        sd_byte_available;
    logic        sd_ready_for_next_byte;
    channel_t    red;
    channel_t    green;
    channel_t    blue;
    logic        busy;
    logic        check_rgb;
    logic        load_image;
    sd_byte_t    card [CARD_BYTES];   // card model storage
    sd_addr_t    wr_log [$];          // sector addresses of write requests
    sd_addr_t    rd_log [$];          // and of read requests
    integer      seed = 32'h2ac0;
    int          timeouts = 0;

    always #20 clk_25mhz = ~clk_25mhz;  // 25 MHz

    frame_buffer_top u_frame_buffer_top (
        .clk_25mhz              (clk_25mhz),
        .reset_SD_card          (reset_SD_card),
        .hcount                 (hcount),
        .vcount                 (vcount),
        .brush_x                (brush_x),
        .brush_y                (brush_y),
        .brush_color            (brush_color),
        .brush_size             (brush_size),
        .draw                   (draw),
        .slide_show             (slide_show),
        .sd_rd                  (sd_rd),
        .sd_wr                  (sd_wr),
        .sd_addr                (sd_addr),
        .sd_din                 (sd_din),
        .sd_ready               (sd_ready),
        .sd_dout                (sd_dout),
        .sd_byte_available      (sd_byte_available),
        .sd_ready_for_next_byte (sd_ready_for_next_byte),
        .red                    (red),
        .green                  (green),
        .blue                   (blue),
        .busy                   (busy)
    );

    frame_checker #(.CARD_AW(CARD_AW)) u_frame_checker (
        .clk_25mhz   (clk_25mhz),
        .check_rgb   (check_rgb),
        .load_image  (load_image),
        .draw        (draw),
        .hcount      (hcount),
        .vcount      (vcount),
        .brush_x     (brush_x),
        .brush_y     (brush_y),
        .brush_color (brush_color),
        .brush_size  (brush_size),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .card        (card)
    );

    task automatic next_cycle();
        @(posedge clk_25mhz);
        #2;                              // inputs change just after the edge
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level && n < BUSY_LIMIT) begin
            next_cycle();
            n++;
        end
        if (busy !== level) begin
            $display("timeout: busy did not go to %b within %0d cycles", level, BUSY_LIMIT);
            timeouts++;
        end
    endtask

    task automatic wait_card_ready();
        int n;
        n = 0;
        while (sd_ready !== 1'b1 && n < CARD_LIMIT) begin
            next_cycle();
            n++;
        end
        if (sd_ready !== 1'b1) begin
            $display("timeout: card model still busy after the operation ended");
            timeouts++;
        end
    endtask

    // card side of a write, sd_din taken three cycles after each request pulse
    task automatic serve_write();
        sd_addr_t base;
        base = sd_addr;
        wr_log.push_back(base);
        sd_ready = 1'b0;
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            repeat (rand_below(4)) next_cycle();
            sd_ready_for_next_byte = 1'b1;
            next_cycle();
            sd_ready_for_next_byte = 1'b0;
            next_cycle();
            next_cycle();
            card[CARD_AW'(base + i)] = sd_din;
        end
        sd_ready = 1'b1;
    endtask

    task automatic serve_read();
        sd_addr_t base;
        int       n;
        base = sd_addr;
        rd_log.push_back(base);
        sd_ready = 1'b0;
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            repeat (rand_below(4)) next_cycle();
            sd_dout           = card[CARD_AW'(base + i)];
            sd_byte_available = 1'b1;
            next_cycle();
            sd_byte_available = 1'b0;
            next_cycle();
        end
        n = 0;
        while (sd_rd === 1'b1 && n < CARD_LIMIT) begin  // read ends when sd_rd drops
            next_cycle();
            n++;
        end
        if (sd_rd === 1'b1) begin
            $display("timeout: sd_rd stayed high after the last byte of a sector");
            timeouts++;
        end
        sd_ready = 1'b1;
    endtask

    initial begin
        next_cycle();
        forever begin
            next_cycle();
            if (sd_wr === 1'b1) begin
                serve_write();
            end else if (sd_rd === 1'b1) begin
                serve_read();
            end
        end
    end

    task automatic scan_frame();
        for (int v = 0; v < FRAME_H; v++) begin
            for (int h = 0; h < FRAME_W; h++) begin
                hcount = x_t'(h);
                vcount = y_t'(v);
                next_cycle();
            end
        end
    endtask

    task automatic paint_stroke(input int x, input int y, input int size, input int color);
        brush_x     = x_t'(x);
        brush_y     = y_t'(y);
        brush_size  = brush_size_t'(size);
        brush_color = color_t'(color);
        next_cycle();                    // painter registers the brush
        scan_frame();
    endtask

    task automatic paint_random(input int strokes);
        for (int i = 0; i < strokes; i++) begin
            paint_stroke(rand_below(FRAME_W), rand_below(FRAME_H), rand_below(8), rand_below(16));
        end
    endtask

    task automatic save_and_check(input int base);
        wr_log.delete();
        draw = 1'b0;                     // pen up starts the save
        wait_busy(1'b1);
        wait_busy(1'b0);
        wait_card_ready();               // last header byte lands in the card
        u_frame_checker.check_saved_image(base);
        u_frame_checker.compare("write requests", 32'(wr_log.size()), 32'(IMAGE_SECTORS + 1));
        for (int i = 0; i < wr_log.size(); i++) begin
            u_frame_checker.compare("sd_addr of write", wr_log[i],
                32'((i < IMAGE_SECTORS) ? base + i * SECTOR_BYTES : HEADER_ADDR));
        end
    endtask

    task automatic load_and_check(input int sectors);
        rd_log.delete();
        slide_show = 1'b1;
        next_cycle();
        slide_show = 1'b0;
        wait_busy(1'b1);
        wait_busy(1'b0);
        wait_card_ready();
        u_frame_checker.compare("read requests", 32'(rd_log.size()), 32'(sectors));
        for (int i = 0; i < rd_log.size(); i++) begin
            u_frame_checker.compare("sd_addr of read", rd_log[i],
                32'((i == 0) ? HEADER_ADDR : IMAGE_BASE + (i - 1) * SECTOR_BYTES));
        end
    endtask

    task automatic scramble_first_image();
        for (int p = 0; p < FRAME_PIXELS; p++) begin
            card[CARD_AW'(IMAGE_BASE + p)] = sd_byte_t'($random(seed));
        end
    endtask

    initial begin
        reset_SD_card          = 1'b1;
        hcount                 = '0;
        vcount                 = '0;
        brush_x                = '0;
        brush_y                = '0;
        brush_color            = '0;
        brush_size             = '0;
        draw                   = 1'b0;
        slide_show             = 1'b0;
        sd_ready               = 1'b1;   // card idle
        sd_dout                = '0;
        sd_byte_available      = 1'b0;
        sd_ready_for_next_byte = 1'b0;
        check_rgb              = 1'b0;
        load_image             = 1'b0;
        for (int a = 0; a < CARD_BYTES; a++) begin
            card[a] = sd_byte_t'(a ^ (a >> 8));  // old card content
        end
        repeat (10) next_cycle();
        reset_SD_card = 1'b0;
        next_cycle();
        u_frame_checker.compare("sd_rd", 32'(sd_rd), 32'd0);
        u_frame_checker.compare("sd_wr", 32'(sd_wr), 32'd0);
        u_frame_checker.compare("busy", 32'(busy), 32'd0);

        // memory has no reset, four wide black strokes cover the whole frame
        draw = 1'b1;
        for (int c = 0; c < 4; c++) begin
            paint_stroke(8 + 16 * c, 8, 7, 0);
        end
        repeat (3) next_cycle();
        check_rgb = 1'b1;
        paint_random(6);
        paint_stroke(12, 8, 2, 8);                 // gray
        paint_stroke(48, 8, 2, 9 + rand_below(7)); // codes above 8 show white
        scan_frame();
        save_and_check(IMAGE_BASE);

        draw = 1'b1;                               // second picture
        paint_random(3);
        save_and_check(IMAGE_BASE + FRAME_PIXELS);

        scramble_first_image();
        check_rgb = 1'b0;                          // store is rewritten during the load
        load_and_check(IMAGE_SECTORS + 1);
        load_image = 1'b1;
        next_cycle();
        load_image = 1'b0;
        repeat (3) next_cycle();
        check_rgb = 1'b1;
        scan_frame();

        // header claims an empty card
        for (int b = 0; b < 4; b++) begin
            card[b] = sd_byte_t'(IMAGE_BASE >> (8 * b));
        end
        scramble_first_image();
        load_and_check(1);
        scan_frame();                              // frame must be unchanged

        repeat (4) next_cycle();
        $display("checks done: %0d mismatches, %0d timeouts", u_frame_checker.errors, timeouts);
        if (u_frame_checker.errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verification/frame_checker.sv
`timescale 1ns/100ps

module frame_checker import frame_pkg::*; #(
    parameter int CARD_AW = 12                 // card model address bits
) (
    input  logic        clk_25mhz,
    input  logic        check_rgb,             // compare the display this cycle
    input  logic        load_image,            // copy the card image into the model
    input  logic        draw,
    input  x_t          hcount,
    input  y_t          vcount,
    input  x_t          brush_x,
    input  y_t          brush_y,
    input  color_t      brush_color,
    input  brush_size_t brush_size,
    input  channel_t    red,
    input  channel_t    green,
    input  channel_t    blue,
    input  sd_byte_t    card [2**CARD_AW]      // contents of the card model
);

    color_t      model [FRAME_PIXELS];  // reference frame
    color_t      read_m;                // store read, one cycle behind the scan
    logic [23:0] rgb_exp;               // palette output, two cycles behind
    logic        drawing_m = 1'b0;
    int          cx_m;                  // brush settings as the painter holds them
    int          cy_m;
    int          size_m;
    color_t      color_m;
    int          scan_idx;
    int          errors = 0;

    // palette table as given for the display
    function automatic logic [23:0] palette(input color_t c);
        case (c)
            4'd0:    return 24'h000000;
            4'd1:    return 24'hffffff;
            4'd2:    return 24'hff0000;
            4'd3:    return 24'h00ff00;
            4'd4:    return 24'h0000ff;
            4'd5:    return 24'h00ffff;
            4'd6:    return 24'hff00ff;
            4'd7:    return 24'hffff00;
            4'd8:    return 24'h808080;
            default: return 24'hffffff;  // 9 to 15
        endcase
    endfunction

    function automatic logic in_brush(input int x, input int y);
        int r;
        r = 2 * (size_m + 1) - 1;        // radius from the size code
        return (x - cx_m) * (x - cx_m) + (y - cy_m) * (y - cy_m) <= r * r;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %0t: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // image bytes at base, then the header with the next free address
    task automatic check_saved_image(input int base);
        logic [31:0] header;
        for (int p = 0; p < FRAME_PIXELS; p++) begin
            compare("card image byte", 32'(card[CARD_AW'(base + p)]),
                    32'(model[pixel_addr_t'(p)]));  // pixel zero-extended
        end
        header = {card[3], card[2], card[1], card[0]};  // lsb first on the card
        compare("header next free", header, 32'(base + FRAME_PIXELS));
        for (int b = 4; b < SECTOR_BYTES; b++) begin
            compare("header padding", 32'(card[CARD_AW'(b)]), 32'd0);
        end
    endtask

    always @(posedge clk_25mhz) begin
        scan_idx = int'(hcount) + FRAME_W * int'(vcount);
        rgb_exp  = palette(read_m);                 // palette register
        read_m   = model[pixel_addr_t'(scan_idx)];  // old content, read before the paint
        if (drawing_m && in_brush(int'(hcount), int'(vcount))) begin
            model[pixel_addr_t'(scan_idx)] = color_m;
        end
        if (load_image) begin
            for (int p = 0; p < FRAME_PIXELS; p++) begin
                model[pixel_addr_t'(p)] = card[CARD_AW'(IMAGE_BASE + p)][3:0];  // low nibble
            end
        end
        drawing_m = draw;                           // drawing state one edge after draw
        cx_m      = int'(brush_x);
        cy_m      = int'(brush_y);
        size_m    = int'(brush_size);
        color_m   = brush_color;
    end

    // outputs settle well before the falling edge
    always @(negedge clk_25mhz) begin
        if (check_rgb) begin
            compare("red", 32'(red), 32'(rgb_exp[23:16]));
            compare("green", 32'(green), 32'(rgb_exp[15:8]));
            compare("blue", 32'(blue), 32'(rgb_exp[7:0]));
        end
    end

endmodule

// File: logic/frame_buffer_top.sv
`timescale 1ns/100ps

module frame_buffer_top import frame_pkg::*; (
    input  logic        clk_25mhz,
    input  logic        reset_SD_card,
    input  x_t          hcount,
    input  y_t          vcount,
    input  x_t          brush_x,
    input  y_t          brush_y,
    input  color_t      brush_color,
    input  brush_size_t brush_size,
    input  logic        draw,
    input  logic        slide_show,
    output logic        sd_rd,
    output logic        sd_wr,
    output sd_addr_t    sd_addr,
    output sd_byte_t    sd_din,
    input  logic        sd_ready,
    input  sd_byte_t    sd_dout,
    input  logic        sd_byte_available,
    input  logic        sd_ready_for_next_byte,
    output channel_t    red,
    output channel_t    green,
    output channel_t    blue,
    output logic        busy
);

    pixel_addr_t scan_addr;    // display scan, also the brush write address
    logic        paint_we;
    color_t      paint_color;
    color_t      pixel_color;  // stored colour of the scanned pixel
    logic        drawing;

    frame_port_if seq_port ();  // sequencer side of the store

    brush_painter u_brush_painter (
        .clk_25mhz   (clk_25mhz),
        .hcount      (hcount),
        .vcount      (vcount),
        .brush_x     (brush_x),
        .brush_y     (brush_y),
        .brush_size  (brush_size),
        .brush_color (brush_color),
        .drawing     (drawing),
        .scan_addr   (scan_addr),
        .paint_we    (paint_we),
        .paint_color (paint_color)
    );

    frame_store u_frame_store (
        .clk_25mhz (clk_25mhz),
        .seq_port  (seq_port.store),
        .b_addr    (scan_addr),
        .b_we      (paint_we),
        .b_wdata   (paint_color),
        .b_rdata   (pixel_color)
    );

    palette_display u_palette_display (
        .clk_25mhz     (clk_25mhz),
        .reset_SD_card (reset_SD_card),
        .pixel_color   (pixel_color),
        .red           (red),
        .green         (green),
        .blue          (blue)
    );

    sd_image_sequencer u_sd_image_sequencer (
        .clk_25mhz              (clk_25mhz),
        .reset_SD_card          (reset_SD_card),
        .draw                   (draw),
        .slide_show             (slide_show),
        .sd_ready               (sd_ready),
        .sd_dout                (sd_dout),
        .sd_byte_available      (sd_byte_available),
        .sd_ready_for_next_byte (sd_ready_for_next_byte),
        .sd_rd                  (sd_rd),
        .sd_wr                  (sd_wr),
        .sd_addr                (sd_addr),
        .sd_din                 (sd_din),
        .drawing                (drawing),
        .busy                   (busy),
        .store                  (seq_port.sequencer)
    );

endmodule

// File: logic/sd_image_sequencer.sv
`timescale 1ns/100ps

module sd_image_sequencer import frame_pkg::*; (
    input  logic            clk_25mhz,
    input  logic            reset_SD_card,
    input  logic            draw,
    input  logic            slide_show,
    input  logic            sd_ready,
    input  sd_byte_t        sd_dout,
    input  logic            sd_byte_available,
    input  logic            sd_ready_for_next_byte,
    output logic            sd_rd,
    output logic            sd_wr,
    output sd_addr_t        sd_addr,
    output sd_byte_t        sd_din,
    output logic            drawing,
    output logic            busy,
    frame_port_if.sequencer store
);

    seq_state_t                      state;
    sd_addr_t                        next_free;   // card address for the next saved image
    logic [$clog2(SECTOR_BYTES)-1:0] byte_cnt;    // byte within the current sector
    pixel_addr_t                     pix_idx;     // frame pixel being saved or loaded
    logic                            slide_q, avail_q, next_q;
    logic                            slide_rise, byte_rise, next_rise;
    logic                            sector_end, image_end;
    sd_byte_t                        header_byte;

    assign slide_rise = slide_show && !slide_q;
    assign byte_rise  = sd_byte_available && !avail_q;      // one read byte per rising edge
    assign next_rise  = sd_ready_for_next_byte && !next_q;  // card wants one more byte

    assign sector_end = &byte_cnt;  // byte 511, sector size is a power of two
    assign image_end  = (pix_idx / SECTOR_BYTES) == IMAGE_SECTORS - 1;

    assign drawing = state == st_drawing;
    assign busy    = !(state inside {st_idle, st_drawing});

    // store port, reads run ahead of the card while saving
    assign store.addr  = pix_idx;
    assign store.wdata = sd_dout[3:0];                     // low nibble holds the colour
    assign store.we    = (state == st_load_sector) && byte_rise;

    // header is the next free address lsb first, then zeros
    assign header_byte = (byte_cnt < 4) ? next_free[byte_cnt[1:0]*8 +: 8] : '0;

    always_ff @(posedge clk_25mhz) begin
        if (next_rise) begin
            sd_din <= (state == st_header_write) ? header_byte : {4'b0, store.rdata};
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (reset_SD_card) begin
            state     <= st_idle;
            next_free <= sd_addr_t'(IMAGE_BASE);  // card treated as empty
            sd_addr   <= sd_addr_t'(HEADER_ADDR);
            sd_rd     <= 1'b0;
            sd_wr     <= 1'b0;
            byte_cnt  <= '0;
            pix_idx   <= '0;
            slide_q   <= 1'b0;
            avail_q   <= 1'b0;
            next_q    <= 1'b0;
        end else begin
            slide_q <= slide_show;
            avail_q <= sd_byte_available;
            next_q  <= sd_ready_for_next_byte;
            sd_wr   <= 1'b0;  // single cycle pulse unless set below
            case (state)
                st_idle: begin
                    if (slide_rise) begin
                        state <= st_load_wait_header;
                    end else if (draw) begin
                        state <= st_drawing;
                    end
                end
                st_drawing: begin
                    if (!draw) begin  // pen up, save the frame
                        state   <= st_save_wait_ready;
                        sd_addr <= next_free;
                        pix_idx <= '0;
                    end
                end
                st_save_wait_ready: begin
                    if (sd_ready) begin
                        sd_wr    <= 1'b1;
                        byte_cnt <= '0;
                        state    <= st_save_sector;
                    end
                end
                st_save_sector: begin
                    if (next_rise) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        pix_idx  <= pix_idx + 1'b1;  // next read overlaps the card gap
                        if (sector_end) begin
                            sd_addr <= sd_addr + SECTOR_BYTES;
                            if (image_end) begin
                                next_free <= sd_addr + SECTOR_BYTES;
                                state     <= st_header_wait_ready;
                            end else begin
                                state <= st_save_wait_ready;
                            end
                        end
                    end
                end
                st_header_wait_ready: begin
                    if (sd_ready) begin
                        sd_wr    <= 1'b1;
                        sd_addr  <= sd_addr_t'(HEADER_ADDR);
                        byte_cnt <= '0;
                        state    <= st_header_write;
                    end
                end
                st_header_write: begin
                    if (next_rise) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (sector_end) begin
                            state <= st_idle;
                        end
                    end
                end
                st_load_wait_header: begin
                    if (sd_ready) begin
                        sd_rd    <= 1'b1;
                        sd_addr  <= sd_addr_t'(HEADER_ADDR);
                        byte_cnt <= '0;
                        state    <= st_load_header;
                    end
                end
                st_load_header: begin
                    if (byte_rise) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt < 4) begin
                            next_free <= {sd_dout, next_free[31:8]};  // lsb arrives first
                        end
                        if (sector_end) begin  // rest of sector 0 is padding
                            sd_rd   <= 1'b0;
                            sd_addr <= sd_addr_t'(IMAGE_BASE);
                            pix_idx <= '0;
                            if (next_free <= sd_addr_t'(IMAGE_BASE)) begin
                                state <= st_idle;  // nothing saved yet, keep the frame
                            end else begin
                                state <= st_load_wait_ready;
                            end
                        end
                    end
                end
                st_load_wait_ready: begin
                    if (sd_ready) begin
                        sd_rd    <= 1'b1;
                        byte_cnt <= '0;
                        state    <= st_load_sector;
                    end
                end
                st_load_sector: begin
                    if (byte_rise) begin  // store write happens on this edge
                        byte_cnt <= byte_cnt + 1'b1;
                        pix_idx  <= pix_idx + 1'b1;
                        if (sector_end) begin
                            sd_rd   <= 1'b0;
                            sd_addr <= sd_addr + SECTOR_BYTES;
                            state   <= image_end ? st_idle : st_load_wait_ready;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: logic/palette_display.sv
`timescale 1ns/100ps

module palette_display import frame_pkg::*; (
    input  logic     clk_25mhz,
    input  logic     reset_SD_card,
    input  color_t   pixel_color,
    output channel_t red,
    output channel_t green,
    output channel_t blue
);

    channel_t lut_r, lut_g, lut_b;

    always_comb begin
        case (pixel_color)
            4'd0:    {lut_r, lut_g, lut_b} = {8'h00, 8'h00, 8'h00}; // black
            4'd1:    {lut_r, lut_g, lut_b} = {8'hff, 8'hff, 8'hff}; // white
            4'd2:    {lut_r, lut_g, lut_b} = {8'hff, 8'h00, 8'h00}; // red
            4'd3:    {lut_r, lut_g, lut_b} = {8'h00, 8'hff, 8'h00}; // green
            4'd4:    {lut_r, lut_g, lut_b} = {8'h00, 8'h00, 8'hff}; // blue
            4'd5:    {lut_r, lut_g, lut_b} = {8'h00, 8'hff, 8'hff}; // cyan
            4'd6:    {lut_r, lut_g, lut_b} = {8'hff, 8'h00, 8'hff}; // magenta
            4'd7:    {lut_r, lut_g, lut_b} = {8'hff, 8'hff, 8'h00}; // yellow
            4'd8:    {lut_r, lut_g, lut_b} = {8'h80, 8'h80, 8'h80}; // mid gray
            default: {lut_r, lut_g, lut_b} = {8'hff, 8'hff, 8'hff}; // unused codes show white
        endcase
    end

    always_ff @(posedge clk_25mhz) begin
        if (reset_SD_card) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            red   <= lut_r;  // second cycle of the display path
            green <= lut_g;
            blue  <= lut_b;
        end
    end

endmodule

// File: logic/frame_store.sv
`timescale 1ns/100ps

module frame_store import frame_pkg::*; (
    input  logic        clk_25mhz,
    frame_port_if.store seq_port,
    input  pixel_addr_t b_addr,
    input  logic        b_we,
    input  color_t      b_wdata,
    output color_t      b_rdata
);

    color_t mem [FRAME_PIXELS];  // one palette index per pixel

    // both ports on one clock, reads see the contents before this edge
    always_ff @(posedge clk_25mhz) begin
        if (seq_port.we) begin
            mem[seq_port.addr] <= seq_port.wdata;  // sd load path
        end
        if (b_we) begin
            mem[b_addr] <= b_wdata;                // brush path, wins on a collision
        end
        seq_port.rdata <= mem[seq_port.addr];      // read-first
        b_rdata        <= mem[b_addr];             // display scan
    end

endmodule

// File: logic/brush_painter.sv
`timescale 1ns/100ps

module brush_painter import frame_pkg::*; (
    input  logic        clk_25mhz,
    input  x_t          hcount,
    input  y_t          vcount,
    input  x_t          brush_x,
    input  y_t          brush_y,
    input  brush_size_t brush_size,
    input  color_t      brush_color,
    input  logic        drawing,
    output pixel_addr_t scan_addr,
    output logic        paint_we,
    output color_t      paint_color
);

    x_t                 centre_x;   // brush settings held for one cycle
    y_t                 centre_y;
    brush_size_t        size_q;
    logic        [3:0]  radius;     // 2 * size + 1, up to 15
    logic        [7:0]  radius_sq;
    logic signed [6:0]  dx;         // covers -63 .. 63
    logic signed [4:0]  dy;         // covers -15 .. 15
    logic        [11:0] dx_sq;
    logic        [7:0]  dy_sq;
    logic        [12:0] dist_sq;
    logic               in_brush;

    always_ff @(posedge clk_25mhz) begin
        centre_x    <= brush_x;     // brush inputs come from slow controls
        centre_y    <= brush_y;
        size_q      <= brush_size;
        paint_color <= brush_color;
    end

    assign radius    = {size_q, 1'b1};  // (size + 1) * 2 - 1
    assign radius_sq = radius * radius;

    assign dx    = $signed({1'b0, hcount}) - $signed({1'b0, centre_x});
    assign dy    = $signed({1'b0, vcount}) - $signed({1'b0, centre_y});
    assign dx_sq = dx * dx;             // signed product, always positive
    assign dy_sq = dy * dy;

    assign dist_sq  = dx_sq + dy_sq;
    assign in_brush = dist_sq <= radius_sq;  // edge of circle counts as inside

    assign scan_addr = {vcount, hcount};     // x + FRAME_W * y, FRAME_W is a power of two
    assign paint_we  = drawing && in_brush;  // write at the edge the pixel is scanned

endmodule

// File: logic/frame_port_if.sv
`timescale 1ns/100ps

interface frame_port_if import frame_pkg::*; ();

    pixel_addr_t addr;  // pixel index, read and write share it
    color_t      wdata; // colour written when we is high
    logic        we;    // write at this clock edge
    color_t      rdata; // old content of addr, one cycle later

    modport sequencer (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport store (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

// File: logic/frame_pkg.sv
package frame_pkg;

    localparam int FRAME_W       = 64;                          // pixels per line
    localparam int FRAME_H       = 16;                          // lines per frame
    localparam int FRAME_PIXELS  = FRAME_W * FRAME_H;           // one byte per pixel on the card
    localparam int SECTOR_BYTES  = 512;                         // sd block size
    localparam int IMAGE_SECTORS = FRAME_PIXELS / SECTOR_BYTES; // two sectors per image
    localparam int IMAGE_BASE    = 512;                         // first image follows the header
    localparam int HEADER_ADDR   = 0;                           // sector 0 holds the next free address

    typedef logic [$clog2(FRAME_W)-1:0]      x_t;          // horizontal coordinate
    typedef logic [$clog2(FRAME_H)-1:0]      y_t;          // vertical coordinate
    typedef logic [$clog2(FRAME_PIXELS)-1:0] pixel_addr_t; // x + FRAME_W * y
    typedef logic [3:0]                      color_t;      // palette index
    typedef logic [7:0]                      channel_t;    // one rgb channel
    typedef logic [31:0]                     sd_addr_t;    // card byte address
    typedef logic [7:0]                      sd_byte_t;    // card data byte
    typedef logic [2:0]                      brush_size_t; // brush size code

    // sequencer states
    typedef enum logic [3:0] {
        st_idle,
        st_drawing,
        st_save_wait_ready,  // wait for card before each image sector
        st_save_sector,
        st_header_wait_ready,
        st_header_write,     // rewrite sector 0 with the new next free address
        st_load_wait_header,
        st_load_header,
        st_load_wait_ready,
        st_load_sector
    } seq_state_t;

endpackage
